//--- hw/forth_pkg.sv
// shared widths, depths and types of the stack processor
// opcode, alu, stack action, error and sequencer state enums

package forth_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////////////////////
  localparam int cell_width  = 32;
  localparam int prog_depth  = 256;
  localparam int stack_depth = 16;

  // one stack item or program word
  typedef logic [cell_width-1:0] cell_t;
  // fetch address into program memory
  typedef logic [$clog2(prog_depth)-1:0] pc_t;
  // 0 to stack_depth, one extra bit for full
  typedef logic [$clog2(stack_depth):0] depth_t;
  typedef logic [7:0] char_t;

  ////////////////////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////////////////////
  // low byte of an opcode word, unknown values run as nop
  typedef enum logic [7:0] {
    op_nop         = 8'h00,
    // these three take the next word as operand
    op_lit         = 8'h01,
    op_branch      = 8'h02,
    op_zero_branch = 8'h03,
    op_plus        = 8'h10,
    op_minus       = 8'h11,
    op_and         = 8'h12,
    op_or          = 8'h13,
    op_xor         = 8'h14,
    op_equal       = 8'h15,
    op_zero_equal  = 8'h16,
    op_dup         = 8'h20,
    op_drop        = 8'h21,
    op_over        = 8'h22,
    op_swap        = 8'h23,
    op_io_led      = 8'h30,
    op_io_button   = 8'h31,
    op_emit        = 8'h32
  } op_e;

  typedef enum logic [2:0] {
    alu_plus, alu_minus, alu_and, alu_or, alu_xor, alu_equal, alu_zero_equal
  } alu_op_e;

  // replace pops two and pushes the alu result
  typedef enum logic [2:0] {
    stk_none, stk_push, stk_pop, stk_replace, stk_replace_top, stk_dup,
    stk_over, stk_swap
  } stack_op_e;

  typedef enum logic [1:0] {
    err_none, err_overflow, err_underflow
  } err_e;

  typedef enum logic [2:0] {
    st_idle, st_execute, st_operand, st_halt
  } seq_state_e;

endpackage

//--- hw/forth_alu.sv
// two-operand arithmetic, logic and compare unit
// flags come out as all ones or zero

`timescale 1ns/1ps

module forth_alu import forth_pkg::*; (
  input  alu_op_e alu_op,
  input  cell_t   top,
  input  cell_t   second,
  output cell_t   result
);

  // second is the deeper operand, so minus is second - top
  always_comb begin
    case (alu_op)
      alu_plus:  result = second + top;
      alu_minus: result = second - top;
      alu_and:   result = second & top;
      alu_or:    result = second | top;
      alu_xor:   result = second ^ top;
      // compare words
      alu_equal: begin
        result = (second == top) ? {cell_width{1'b1}} : '0;
      end
      // only looks at top
      alu_zero_equal: begin
        result = (top == '0) ? {cell_width{1'b1}} : '0;
      end
      default: result = '0;
    endcase
  end

endmodule

//--- hw/forth_data_stack.sv
// data stack with top register, spill array and depth count
// flags overflow and underflow before the action takes place

`timescale 1ns/1ps

module forth_data_stack import forth_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      stack_clear,
  input  stack_op_e stack_op,
  input  cell_t     push_value,
  input  cell_t     result,
  output cell_t     top,
  output cell_t     second,
  output err_e      stack_error
);

  // items below top, slot 0 is the bottom
  cell_t  below [stack_depth];
  depth_t depth;
  // items the action needs on the stack
  logic [1:0] need;
  logic       grows;
  logic [$clog2(stack_depth)-1:0] spill_idx;
  logic [$clog2(stack_depth)-1:0] second_idx;

  // spill slot takes old top, second sits one lower
  assign spill_idx  = depth[$clog2(stack_depth)-1:0] - 1'b1;
  assign second_idx = depth[$clog2(stack_depth)-1:0] - 2'd2;
  assign second     = below[second_idx];

  always_comb begin
    need  = 2'd0;
    grows = 1'b0;
    case (stack_op)
      stk_push:                 grows = 1'b1;
      stk_pop, stk_replace_top: need = 2'd1;
      stk_dup: begin
        need  = 2'd1;
        grows = 1'b1;
      end
      stk_replace, stk_swap:    need = 2'd2;
      stk_over: begin
        need  = 2'd2;
        grows = 1'b1;
      end
      default: ;
    endcase
  end

  // underflow wins when both could apply
  always_comb begin
    if (depth < depth_t'(need)) stack_error = err_underflow;
    else if (grows && depth == depth_t'(stack_depth)) stack_error = err_overflow;
    else stack_error = err_none;
  end

  always_ff @(posedge clk) begin
    if (!reset || stack_clear) begin
      depth <= '0;
    end else if (stack_error == err_none) begin
      case (stack_op)
        stk_push, stk_dup, stk_over: depth <= depth + 1'b1;
        stk_pop, stk_replace:        depth <= depth - 1'b1;
        default: ;
      endcase
    end
  end

  // payload path, contents frozen on error
  always_ff @(posedge clk) begin
    if (!stack_clear && stack_error == err_none) begin
      case (stack_op)
        stk_push: begin
          below[spill_idx] <= top;
          top              <= push_value;
        end
        stk_pop:                      top <= second;
        stk_replace, stk_replace_top: top <= result;
        stk_dup:                      below[spill_idx] <= top;
        stk_over: begin
          below[spill_idx] <= top;
          top              <= second;
        end
        stk_swap: begin
          below[second_idx] <= top;
          top               <= second;
        end
        default: ;
      endcase
    end
  end

endmodule

//--- hw/forth_program_memory.sv
// program word store
// synchronous load port, asynchronous fetch read

`timescale 1ns/1ps

module forth_program_memory import forth_pkg::*; (
  input  logic  clk,
  input  logic  load_en,
  input  pc_t   load_addr,
  input  cell_t load_data,
  input  pc_t   pc,
  output cell_t instr
);

  cell_t mem [prog_depth];

  // loaded while the core is held idle
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  // fetch word visible in the same cycle
  assign instr = mem[pc];

endmodule

//--- hw/forth_io_port.sv
// led register, two-flop button synchronizer
// emit character register and one-cycle strobe

`timescale 1ns/1ps

module forth_io_port import forth_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  cell_t      top,
  input  logic       led_write,
  input  logic       emit_write,
  input  logic [1:0] buttons,
  output logic [1:0] leds,
  output logic [1:0] sync_buttons,
  output logic       emit_strobe,
  output char_t      emit_char
);

  // first synchronizer stage
  logic [1:0] buttons_meta;

  always_ff @(posedge clk) begin
    if (!reset) begin
      leds         <= '0;
      buttons_meta <= '0;
      sync_buttons <= '0;
      emit_strobe  <= 1'b0;
    end else begin
      // low two bits of top, held until the next store
      if (led_write) leds <= top[1:0];
      buttons_meta <= buttons;
      sync_buttons <= buttons_meta;
      // strobe in the cycle after the accepted emit
      emit_strobe  <= emit_write;
    end
  end

  // character only changes on an accepted emit
  always_ff @(posedge clk) begin
    if (emit_write) begin
      emit_char <= top[7:0];
    end
  end

endmodule

//--- hw/forth_sequencer.sv
// control FSM of the stack processor
// fetch, decode, operand handling, halt and error latch

`timescale 1ns/1ps

module forth_sequencer import forth_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      run,
  input  cell_t     instr,
  input  cell_t     top,
  input  err_e      stack_error,
  input  logic      tx_ready,
  input  logic [1:0] sync_buttons,
  output pc_t       pc,
  output stack_op_e stack_op,
  output cell_t     push_value,
  output alu_op_e   alu_op,
  output logic      stack_clear,
  output logic      led_write,
  output logic      emit_write,
  output logic      halted,
  output err_e      error
);

  seq_state_e state, state_next;
  pc_t        pc_next;
  op_e        op;
  // opcode waiting for its operand word
  op_e        pend_op;
  // flag seen by zero branch in its execute cycle
  logic       flag_zero;
  logic       emit_go;

  assign op = op_e'(instr[7:0]);

  ////////////////////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    state_next = state;
    pc_next    = pc;
    stack_op   = stk_none;
    alu_op     = alu_plus;
    push_value = instr;
    led_write  = 1'b0;
    emit_go    = 1'b0;
    case (state)
      st_idle: begin
        if (run) begin
          state_next = st_execute;
          pc_next    = '0;
        end
      end
      st_execute: begin
        pc_next = pc + 1'b1;
        case (op)
          op_lit, op_branch: state_next = st_operand;
          // flag leaves the stack now, target comes next cycle
          op_zero_branch: begin
            stack_op   = stk_pop;
            state_next = st_operand;
          end
          op_plus:  begin stack_op = stk_replace; alu_op = alu_plus;  end
          op_minus: begin stack_op = stk_replace; alu_op = alu_minus; end
          op_and:   begin stack_op = stk_replace; alu_op = alu_and;   end
          op_or:    begin stack_op = stk_replace; alu_op = alu_or;    end
          op_xor:   begin stack_op = stk_replace; alu_op = alu_xor;   end
          op_equal: begin stack_op = stk_replace; alu_op = alu_equal; end
          op_zero_equal: begin
            stack_op = stk_replace_top;
            alu_op   = alu_zero_equal;
          end
          op_dup:  stack_op = stk_dup;
          op_drop: stack_op = stk_pop;
          op_over: stack_op = stk_over;
          op_swap: stack_op = stk_swap;
          // depth unchanged, top just copied out
          op_io_led: led_write = 1'b1;
          op_io_button: begin
            stack_op   = stk_push;
            push_value = cell_t'(sync_buttons);
          end
          op_emit: begin
            if (tx_ready) begin
              stack_op = stk_pop;
              emit_go  = 1'b1;
            end else begin
              // back-pressure, hold on this opcode
              pc_next = pc;
            end
          end
          default: ;
        endcase
      end
      st_operand: begin
        pc_next    = pc + 1'b1;
        state_next = st_execute;
        case (pend_op)
          op_lit:    stack_op = stk_push;
          op_branch: pc_next = pc_t'(instr);
          op_zero_branch: begin
            if (flag_zero) pc_next = pc_t'(instr);
          end
          default: ;
        endcase
      end
      default: ;
    endcase
  end

  // no character goes out when the pop faults
  assign emit_write  = emit_go && (stack_error == err_none);
  assign stack_clear = !run || (state == st_idle);
  assign halted      = (state == st_halt);

  ////////////////////////////////////////////////////////////////////////////
  // state, pc and error
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!reset) begin
      state     <= st_idle;
      pc        <= '0;
      error     <= err_none;
      pend_op   <= op_nop;
      flag_zero <= 1'b0;
    end else if (!run) begin
      state <= st_idle;
      pc    <= '0;
      error <= err_none;
    end else if ((state == st_execute || state == st_operand) &&
                 stack_error != err_none) begin
      // stack kept its contents, stop here
      state <= st_halt;
      error <= stack_error;
    end else begin
      state <= state_next;
      pc    <= pc_next;
      if (state == st_execute) begin
        pend_op   <= op;
        flag_zero <= (top == '0);
      end
    end
  end

endmodule

//--- hw/forth_core.sv
// top level of the stack processor
// sequencer plus program memory, data stack, alu and io port

`timescale 1ns/1ps

module forth_core import forth_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       run,
  input  logic       load_en,
  input  pc_t        load_addr,
  input  cell_t      load_data,
  input  logic [1:0] buttons,
  input  logic       tx_ready,
  output logic [1:0] leds,
  output logic       emit_strobe,
  output char_t      emit_char,
  output logic       halted,
  output err_e       error
);

  pc_t        pc;
  cell_t      instr;
  stack_op_e  stack_op;
  cell_t      push_value;
  alu_op_e    alu_op;
  logic       stack_clear;
  cell_t      top;
  cell_t      second;
  cell_t      result;
  err_e       stack_error;
  logic       led_write;
  logic       emit_write;
  logic [1:0] sync_buttons;

  ////////////////////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////////////////////
  forth_sequencer i_sequencer (
    .clk, .reset, .run, .instr, .top, .stack_error, .tx_ready, .sync_buttons,
    .pc, .stack_op, .push_value, .alu_op, .stack_clear, .led_write,
    .emit_write, .halted, .error
  );

  forth_program_memory i_program_memory (
    .clk, .load_en, .load_addr, .load_data, .pc, .instr
  );

  ////////////////////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////////////////////
  forth_data_stack i_data_stack (
    .clk, .reset, .stack_clear, .stack_op, .push_value, .result,
    .top, .second, .stack_error
  );

  forth_alu i_alu (.alu_op, .top, .second, .result);

  forth_io_port i_io_port (
    .clk, .reset, .top, .led_write, .emit_write, .buttons,
    .leds, .sync_buttons, .emit_strobe, .emit_char
  );

endmodule

//--- verif/forth_core_sva.sv
// concurrent assertions on emit strobe, halt and reset values
// bound into the core top level

`timescale 1ns/1ps

module forth_core_sva import forth_pkg::*; (
  input logic clk,
  input logic reset,
  input logic tx_ready,
  input logic emit_strobe,
  input logic halted,
  input err_e error
);

  // count of failed assertions
  int fail_count = 0;

  // strobe is a single-cycle pulse
  strobe_single: assert property (
    @(posedge clk) disable iff (!reset) emit_strobe |=> !emit_strobe
  ) else begin
    fail_count++;
    $error("emit_strobe stayed high for two cycles");
  end

  // strobe only after the transmitter was ready
  strobe_after_ready: assert property (
    @(posedge clk) disable iff (!reset) emit_strobe |-> $past(tx_ready)
  ) else begin
    fail_count++;
    $error("emit_strobe without tx_ready in the cycle before");
  end

  // a halt always carries its code and sends nothing
  halt_has_code: assert property (
    @(posedge clk) disable iff (!reset)
      halted |-> (error != err_none && !emit_strobe)
  ) else begin
    fail_count++;
    $error("halted high with error at err_none or with emit_strobe high");
  end

  // reset leaves strobe and halt low
  reset_values: assert property (
    @(posedge clk) !reset |=> (!emit_strobe && !halted)
  ) else begin
    fail_count++;
    $error("emit_strobe or halted high after reset");
  end

endmodule

bind forth_core forth_core_sva i_sva (
  .clk, .reset, .tx_ready, .emit_strobe, .halted, .error
);

//--- verif/tb_forth_core.sv
// testbench of the stack processor core
// random program generator, queue-based reference model, emit monitor, watchdog

`timescale 1ns/1ps

module tb_forth_core import forth_pkg::*; ();

  localparam int clk_period     = 8;
  localparam int num_programs   = 40;
  localparam int program_cycles = 2000;
  localparam int settle_cycles  = 40;

  logic       clk;
  logic       reset;
  logic       run;
  logic       load_en;
  pc_t        load_addr;
  cell_t      load_data;
  logic [1:0] buttons;
  logic       tx_ready;
  logic [1:0] leds;
  logic       emit_strobe;
  char_t      emit_char;
  logic       halted;
  err_e       error;

  integer     seed;
  // program under construction and generator depth
  cell_t      prog [$];
  int         gen_depth;
  // model predictions
  char_t      exp_chars [$];
  logic [1:0] model_leds;
  err_e       exp_error;
  int         emit_count;
  int         prog_idx;

  forth_core i_dut (
    .clk, .reset, .run, .load_en, .load_addr, .load_data, .buttons, .tx_ready,
    .leds, .emit_strobe, .emit_char, .halted, .error
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reporting
  ////////////////////////////////////////////////////////////////////////////
  task automatic fail_run(string why);
    $display("ERROR: %s", why);
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      fail_run($sformatf("%s does not match the model", name));
    end
  endtask

  function automatic int rand_below(int n);
    return $unsigned($random(seed)) % n;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // program generator
  ////////////////////////////////////////////////////////////////////////////
  // opcode in the low byte, junk above it
  task automatic add_op(op_e op);
    cell_t word;
    word      = $random(seed);
    word[7:0] = op;
    prog.push_back(word);
  endtask

  task automatic add_lit(cell_t value);
    add_op(op_lit);
    prog.push_back(value);
  endtask

  // zeros and small values make compares hit
  function automatic cell_t pick_value();
    case (rand_below(4))
      0: return '0;
      1: return cell_t'(rand_below(4));
      default: return $random(seed);
    endcase
  endfunction

  task automatic add_random_op();
    op_e op;
    int  delta;
    case (rand_below(16))
      0: op = op_plus;
      1: op = op_minus;
      2: op = op_and;
      3: op = op_or;
      4: op = op_xor;
      5: op = op_equal;
      6: op = op_zero_equal;
      7: op = op_dup;
      8: op = op_drop;
      9: op = op_over;
      10: op = op_swap;
      11: op = op_io_led;
      12: op = op_io_button;
      13: op = op_emit;
      14: op = op_lit;
      // unassigned code, runs as nop
      default: op = op_e'(8'h7e);
    endcase
    case (op)
      op_dup, op_over, op_io_button, op_lit: delta = 1;
      op_plus, op_minus, op_and, op_or, op_xor, op_equal, op_drop, op_emit: delta = -1;
      default: delta = 0;
    endcase
    // depth stays within 2..14
    if (gen_depth + delta < 2 || gen_depth + delta > 14) begin
      op    = op_swap;
      delta = 0;
    end
    if (op == op_lit) add_lit(pick_value());
    else add_op(op);
    gen_depth += delta;
  endtask

  // counts n down to 1, emitting each count, depth peaks 2 above start
  task automatic add_countdown();
    int loop_addr;
    int exit_slot;
    add_lit(cell_t'(1 + rand_below(5)));
    loop_addr = prog.size();
    add_op(op_dup);
    add_op(op_emit);
    add_lit(cell_t'(1));
    add_op(op_minus);
    add_op(op_dup);
    add_op(op_zero_branch);
    exit_slot = prog.size();
    prog.push_back('0);
    add_op(op_branch);
    prog.push_back(cell_t'(loop_addr));
    prog[exit_slot] = cell_t'(prog.size());
    add_op(op_drop);
  endtask

  task automatic build_program(bit make_error);
    int n_lits;
    int n_ops;
    int loop_at;
    int self_addr;
    prog.delete();
    gen_depth = 0;
    n_lits    = 2 + rand_below(3);
    repeat (n_lits) begin
      add_lit(pick_value());
      gen_depth++;
    end
    n_ops   = 8 + rand_below(20);
    loop_at = (rand_below(3) == 0) ? rand_below(n_ops) : -1;
    for (int i = 0; i < n_ops; i++) begin
      if (i == loop_at && gen_depth <= 12) add_countdown();
      add_random_op();
    end
    add_op(op_io_button);
    add_op(op_emit);
    // runaway tail, faults within 20 words
    if (make_error) begin
      case (rand_below(4))
        0: repeat (20) add_op(op_drop);
        1: repeat (20) add_op(op_emit);
        2: repeat (20) add_op(op_dup);
        default: repeat (20) add_lit(pick_value());
      endcase
    end
    add_op(op_emit);
    self_addr = prog.size();
    add_op(op_branch);
    prog.push_back(cell_t'(self_addr));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////
  function automatic cell_t flag(bit cond);
    return cond ? ~cell_t'(0) : cell_t'(0);
  endfunction

  // a is the deeper item
  function automatic cell_t apply_binop(op_e op, cell_t a, cell_t b);
    case (op)
      op_plus: return a + b;
      op_minus: return a - b;
      op_and: return a & b;
      op_or: return a | b;
      op_xor: return a ^ b;
      default: return flag(a == b);
    endcase
  endfunction

  task automatic run_model();
    cell_t stk [$];
    cell_t a;
    cell_t b;
    op_e   op;
    int    pc;
    int    steps;
    int    need;
    bit    grows;
    bit    done;
    exp_chars.delete();
    exp_error = err_none;
    pc        = 0;
    steps     = 0;
    done      = 1'b0;
    while (!done) begin
      op    = op_e'(prog[pc][7:0]);
      need  = 0;
      grows = 1'b0;
      steps++;
      if (steps > program_cycles) fail_run("model never reached the closing loop");
      // items each word needs, and whether it adds one
      case (op)
        op_lit, op_io_button: grows = 1'b1;
        op_zero_branch, op_zero_equal, op_drop, op_emit: need = 1;
        op_plus, op_minus, op_and, op_or, op_xor, op_equal, op_swap: need = 2;
        op_dup: begin
          need  = 1;
          grows = 1'b1;
        end
        op_over: begin
          need  = 2;
          grows = 1'b1;
        end
        default: ;
      endcase
      if (stk.size() < need) begin
        exp_error = err_underflow;
        done      = 1'b1;
      end else if (grows && stk.size() == stack_depth) begin
        exp_error = err_overflow;
        done      = 1'b1;
      end else begin
        case (op)
          op_lit: stk.push_back(prog[pc + 1]);
          // branch to itself is the closing loop
          op_branch: begin
            if (int'(prog[pc + 1][7:0]) == pc) done = 1'b1;
            else pc = int'(prog[pc + 1][7:0]);
          end
          op_zero_branch: begin
            a  = stk.pop_back();
            pc = (a == '0) ? int'(prog[pc + 1][7:0]) : pc + 2;
          end
          op_plus, op_minus, op_and, op_or, op_xor, op_equal: begin
            b = stk.pop_back();
            a = stk.pop_back();
            stk.push_back(apply_binop(op, a, b));
          end
          op_zero_equal: begin
            a = stk.pop_back();
            stk.push_back(flag(a == '0));
          end
          op_dup: stk.push_back(stk[$]);
          op_drop: void'(stk.pop_back());
          op_over: stk.push_back(stk[$-1]);
          op_swap: begin
            b = stk.pop_back();
            a = stk.pop_back();
            stk.push_back(b);
            stk.push_back(a);
          end
          op_io_led: model_leds = stk[$][1:0];
          op_io_button: stk.push_back(cell_t'(buttons));
          op_emit: begin
            a = stk.pop_back();
            exp_chars.push_back(a[7:0]);
          end
          default: ;
        endcase
        if (op == op_lit) pc += 2;
        else if (op != op_branch && op != op_zero_branch) pc++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // program run
  ////////////////////////////////////////////////////////////////////////////
  task automatic run_program(int idx);
    int n_chars;
    int cycles;
    bit finished;
    @(negedge clk);
    run = 1'b0;
    repeat (2) @(negedge clk);
    // run low clears halt and error
    check_value("halted", 32'(halted), 32'(0));
    check_value("error", 32'(error), 32'(err_none));
    buttons = 2'(rand_below(4));
    run_model();
    n_chars    = exp_chars.size();
    emit_count = 0;
    foreach (prog[i]) begin
      load_en   = 1'b1;
      load_addr = pc_t'(i);
      load_data = prog[i];
      @(negedge clk);
    end
    load_en = 1'b0;
    // buttons settle through the synchronizer
    repeat (3) @(negedge clk);
    run      = 1'b1;
    cycles   = 0;
    finished = 1'b0;
    while (!finished) begin
      @(negedge clk);
      cycles++;
      if (exp_error == err_none) finished = (emit_count == n_chars);
      else finished = (halted === 1'b1);
      if (!finished && cycles > program_cycles) begin
        fail_run($sformatf("program %0d did not finish within %0d cycles", idx,
                           program_cycles));
      end
    end
    // closing loop must stay quiet
    repeat (settle_cycles) @(negedge clk);
    check_value("halted", 32'(halted), 32'(exp_error != err_none));
    check_value("error", 32'(error), 32'(exp_error));
    check_value("emit count", 32'(emit_count), 32'(n_chars));
    check_value("leds", 32'(leds), 32'(model_leds));
  endtask

  // emit monitor, then the next tx_ready level
  initial begin
    char_t exp_char;
    tx_ready = 1'b0;
    forever begin
      @(negedge clk);
      if (emit_strobe === 1'b1) begin
        if (tx_ready !== 1'b1) fail_run("emit_strobe did not follow a tx_ready high cycle");
        if (exp_chars.size() == 0) fail_run("emit_strobe with no character left in the model");
        exp_char = exp_chars.pop_front();
        check_value("emit_char", 32'(emit_char), 32'(exp_char));
        emit_count++;
        // transmitter busy for a cycle after taking a character
        tx_ready = 1'b0;
      end else begin
        tx_ready = 1'(rand_below(2));
      end
    end
  end

  initial begin
    repeat (num_programs * program_cycles) @(posedge clk);
    fail_run("watchdog expired before all programs finished");
  end

  initial begin
    seed       = 32'he691;
    reset      = 1'b0;
    run        = 1'b0;
    load_en    = 1'b0;
    load_addr  = '0;
    load_data  = '0;
    buttons    = 2'b00;
    model_leds = 2'b00;
    exp_error  = err_none;
    emit_count = 0;
    repeat (4) @(negedge clk);
    reset = 1'b1;
    // every fifth program ends in a stack fault
    for (prog_idx = 0; prog_idx < num_programs; prog_idx++) begin
      build_program(prog_idx % 5 == 4);
      run_program(prog_idx);
    end
    if (i_dut.i_sva.fail_count != 0) begin
      fail_run("a bound assertion reported a failure");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

//--- verilog.f
hw/forth_pkg.sv
hw/forth_alu.sv
hw/forth_data_stack.sv
hw/forth_program_memory.sv
hw/forth_io_port.sv
hw/forth_sequencer.sv
hw/forth_core.sv
verif/forth_core_sva.sv
verif/tb_forth_core.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_forth_core
FILELIST = verilog.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
